//--- sources.f
design/vend_pkg.sv
design/disp_pkg.sv
design/input_conditioner.sv
design/tick_gen.sv
design/drink_selector.sv
design/credit_fsm.sv
design/display_scan.sv
design/vending_top.sv
test/vending_tb.sv

//--- Bender.yml
package:
  name: vending_machine

sources:
  - files:
      - design/vend_pkg.sv
      - design/disp_pkg.sv
      - design/input_conditioner.sv
      - design/tick_gen.sv
      - design/drink_selector.sv
      - design/credit_fsm.sv
      - design/display_scan.sv
      - design/vending_top.sv
  - target: simulation
    files:
      - test/vending_tb.sv

//--- test/vending_tb.sv
`timescale 1ns/100ps
`default_nettype none

module vending_tb;

    import vend_pkg::*;
    import disp_pkg::*;

    localparam int DEBOUNCE_LEN = 4;
    localparam int REFUND_DIV   = 8;
    localparam int SCAN_DIV     = 4;
    localparam int TIMEOUT      = 500;

    localparam logic [1:0] ACT_COIN   = 2'd0;
    localparam logic [1:0] ACT_GLITCH = 2'd1;
    localparam logic [1:0] ACT_KEY    = 2'd2;
    localparam logic [1:0] ACT_CANCEL = 2'd3;   // val is a coin pushed during the refund

    typedef struct packed {
        logic [1:0] act;
        logic [8:0] val;
        money_t     money;
        drink_t     drinks;
        drink_t     disp;
    } row_t;

    logic      clk;
    logic      rst_n;
    coin_t     coin;
    logic      cancel;
    logic      key_valid;
    key_code_t key_code;
    money_t    money;
    drink_t    drinks;
    drink_t    dispense;
    logic      refunding;
    anode_t    an;
    seg_t      seg;

    row_t       rows [$];
    int         errors;
    int         checks;
    drink_t     disp_seen;
    int         disp_cnt;
    logic       refund_seen;
    money_t     prev_money;
    logic       prev_refunding;
    seg_t       cap [3];
    logic [2:0] cap_ok;
    logic       overlap;
    money_t     model_money;
    drink_t     exp_disp;
    logic       exp_refund;
    money_t     exp_cost;

    vending_top #(
        .DEBOUNCE_LEN (DEBOUNCE_LEN),
        .REFUND_DIV   (REFUND_DIV),
        .SCAN_DIV     (SCAN_DIV)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .coin      (coin),
        .cancel    (cancel),
        .key_valid (key_valid),
        .key_code  (key_code),
        .money     (money),
        .drinks    (drinks),
        .dispense  (dispense),
        .refunding (refunding),
        .an        (an),
        .seg       (seg)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("ERROR: %s", what);
        errors++;
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!rst_n) begin
            if (dispense != '0) begin
                disp_seen = disp_seen | dispense;
                disp_cnt++;
                check_value("purchase_cost", prev_money - money, exp_cost);
            end
            if (refunding) begin
                refund_seen = 1'b1;
            end
            if (prev_refunding && money != prev_money) begin
                check_value("refund_step", prev_money - money, REFUND_STEP);
            end
            if ($countones(~an) > 1) begin
                overlap = 1'b1;
            end
            for (int i = 0; i < 3; i++) begin
                if (an[i] == 1'b0) begin   // bit 0 ones, bit 1 tens, bit 2 hundreds
                    cap[i]    = seg;
                    cap_ok[i] = 1'b1;
                end
            end
            prev_money     = money;
            prev_refunding = refunding;
        end
    end

    function automatic drink_t available(input money_t m);
        return {m >= PRICE_COFFEE, m >= PRICE_COKE, m >= PRICE_OOLONG, m >= PRICE_WATER};
    endfunction

    function automatic seg_t seg_of(input int d);
        case (d)
            0: return 7'b0000001;
            1: return 7'b1001111;
            2: return 7'b0010010;
            3: return 7'b0000110;
            4: return 7'b1001100;
            5: return 7'b0100100;
            6: return 7'b0100000;
            7: return 7'b0001111;
            8: return 7'b0000000;
            9: return 7'b0000100;
            default: return SEG_BLANK;
        endcase
    endfunction

    task automatic model_step(input row_t r);
        int     v;
        money_t price;
        drink_t pick;
        v = (r.val == COIN_50) ? COIN_VALUE_50 : (r.val == COIN_10) ? COIN_VALUE_10 :
            (r.val == COIN_5) ? COIN_VALUE_5 : 0;
        pick = (r.val == KEY_COFFEE) ? DRINK_COFFEE : (r.val == KEY_COKE) ? DRINK_COKE :
               (r.val == KEY_OOLONG) ? DRINK_OOLONG : (r.val == KEY_WATER) ? DRINK_WATER : '0;
        price = (r.val == KEY_COFFEE) ? PRICE_COFFEE : (r.val == KEY_COKE) ? PRICE_COKE :
                (r.val == KEY_OOLONG) ? PRICE_OOLONG : PRICE_WATER;
        exp_disp   = '0;
        exp_refund = 1'b0;
        exp_cost   = '0;
        if (r.act == ACT_COIN) begin
            model_money = (model_money + v > CREDIT_MAX) ? CREDIT_MAX : model_money + v;
        end else if (r.act == ACT_KEY && pick != '0 && price <= model_money) begin
            exp_disp    = pick;
            exp_refund  = 1'b1;
            exp_cost    = price;
            model_money = '0;   // change is refunded after the sale
        end else if (r.act == ACT_CANCEL && model_money != '0) begin
            exp_refund  = 1'b1;
            model_money = '0;
        end
    endtask

    task automatic hold_coin(input coin_t c, input int cycles);
        coin = c;
        repeat (cycles) @(negedge clk);
        coin = '0;
    endtask

    task automatic wait_refund_start();
        int n;
        n = 0;
        while (!refunding && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!refunding) begin
            report_problem("refund did not start after cancel");
        end
    endtask

    task automatic wait_settle(input money_t exp);
        int n;
        n = 0;
        while ((money !== exp || refunding !== 1'b0) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (money !== exp || refunding !== 1'b0) begin
            report_problem($sformatf("credit did not settle at %0d in time", exp));
        end
    endtask

    task automatic check_display(input money_t m);
        int hund;
        int tens;
        hund = (m >= 100) ? m / 100 : 10;
        tens = (m >= 10) ? (m / 10) % 10 : 10;
        repeat (NUM_DIGITS * SCAN_DIV) @(negedge clk);   // let older digits scan out
        cap_ok = '0;
        repeat ((NUM_DIGITS + 1) * SCAN_DIV) @(negedge clk);
        if (cap_ok != 3'b111) begin
            report_problem("a display position was never enabled");
        end
        check_value("seg_ones", cap[0], seg_of(m % 10));
        check_value("seg_tens", cap[1], seg_of(tens));
        check_value("seg_hundreds", cap[2], seg_of(hund));
    endtask

    task automatic run_row(input int idx, input row_t r);
        int err0;
        err0        = errors;
        disp_seen   = '0;
        disp_cnt    = 0;
        refund_seen = 1'b0;
        overlap     = 1'b0;
        model_step(r);
        case (r.act)
            ACT_COIN: hold_coin(r.val[2:0], DEBOUNCE_LEN + 2);
            ACT_GLITCH: hold_coin(r.val[2:0], 2);
            ACT_KEY: begin
                key_code  = r.val;
                key_valid = 1'b1;
                @(negedge clk);
                key_valid = 1'b0;
            end
            default: begin
                cancel = 1'b1;
                repeat (DEBOUNCE_LEN + 2) @(negedge clk);
                cancel = 1'b0;
                if (r.val != '0) begin
                    wait_refund_start();
                    hold_coin(r.val[2:0], DEBOUNCE_LEN + 2);
                end
            end
        endcase
        repeat (3) @(negedge clk);   // selector and credit register latency
        wait_settle(r.money);
        check_value("money", money, r.money);
        check_value("drinks", drinks, r.drinks);
        check_value("dispense", disp_seen, r.disp);
        check_value("dispense_pulses", disp_cnt, (r.disp != '0) ? 1 : 0);
        check_value("refunding_seen", refund_seen, exp_refund);
        check_value("model_money", model_money, r.money);
        check_value("model_drinks", available(model_money), r.drinks);
        check_value("model_dispense", exp_disp, r.disp);
        check_display(r.money);
        if (overlap) begin
            report_problem("two anodes were enabled at the same time");
        end
        $display("row %0d action %0d value 0x%0h: %0d errors", idx, r.act, r.val, errors - err0);
    endtask

    task automatic add_row(input logic [1:0] act, input logic [8:0] val, input money_t m,
                           input drink_t d, input drink_t dsp);
        row_t r;
        r = '{act, val, m, d, dsp};
        rows.push_back(r);
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b1;
        coin           = '0;
        cancel         = 1'b0;
        key_valid      = 1'b0;
        key_code       = '0;
        errors         = 0;
        checks         = 0;
        model_money    = '0;
        prev_money     = '0;
        prev_refunding = 1'b0;
        cap_ok         = '0;
        add_row(ACT_COIN, COIN_5, 8'd5, 4'b0000, 4'b0000);
        add_row(ACT_COIN, COIN_10, 8'd15, 4'b0000, 4'b0000);
        add_row(ACT_GLITCH, COIN_5, 8'd15, 4'b0000, 4'b0000);
        add_row(ACT_COIN, COIN_10, 8'd25, 4'b0011, 4'b0000);
        add_row(ACT_COIN, COIN_5, 8'd30, 4'b0111, 4'b0000);
        add_row(ACT_KEY, KEY_COFFEE, 8'd30, 4'b0111, 4'b0000);
        add_row(ACT_KEY, 9'h015, 8'd30, 4'b0111, 4'b0000);
        add_row(ACT_KEY, KEY_COKE, 8'd0, 4'b0000, DRINK_COKE);
        add_row(ACT_COIN, COIN_50, 8'd50, 4'b0111, 4'b0000);
        add_row(ACT_COIN, COIN_50, 8'd100, 4'b1111, 4'b0000);
        add_row(ACT_COIN, COIN_10, 8'd100, 4'b1111, 4'b0000);
        add_row(ACT_KEY, KEY_WATER, 8'd0, 4'b0000, DRINK_WATER);
        add_row(ACT_COIN, COIN_50, 8'd50, 4'b0111, 4'b0000);
        add_row(ACT_COIN, COIN_10, 8'd60, 4'b0111, 4'b0000);
        add_row(ACT_CANCEL, COIN_10, 8'd0, 4'b0000, 4'b0000);
        add_row(ACT_CANCEL, 9'h000, 8'd0, 4'b0000, 4'b0000);
        add_row(ACT_COIN, COIN_5, 8'd5, 4'b0000, 4'b0000);
        repeat (2) @(negedge clk);
        rst_n = 1'b0;
        @(negedge clk);
        foreach (rows[i]) begin
            run_row(i, rows[i]);
        end
        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/vending_top.sv
`timescale 1ns/100ps
`default_nettype none

module vending_top #(
    parameter int DEBOUNCE_LEN = 4,
    parameter int REFUND_DIV   = 8,
    parameter int SCAN_DIV     = 4
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire vend_pkg::coin_t     coin,
    input  wire logic                cancel,
    input  wire logic                key_valid,
    input  wire vend_pkg::key_code_t key_code,
    output vend_pkg::money_t         money,
    output vend_pkg::drink_t         drinks,
    output vend_pkg::drink_t         dispense,
    output logic                     refunding,
    output disp_pkg::anode_t         an,
    output disp_pkg::seg_t           seg
);

    import vend_pkg::*;

    coin_t  coin_pulse;
    logic   cancel_pulse;
    logic   buy;
    drink_t buy_drink;
    money_t buy_cost;
    logic   refund_tick;
    logic   scan_tick;

    input_conditioner #(
        .sig_t        (coin_t),
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) coin_cond (
        .clk   (clk),
        .rst_n (rst_n),
        .raw   (coin),
        .pulse (coin_pulse)
    );

    input_conditioner #(
        .sig_t        (logic),
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) cancel_cond (
        .clk   (clk),
        .rst_n (rst_n),
        .raw   (cancel),
        .pulse (cancel_pulse)
    );

    drink_selector i_selector (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_valid (key_valid),
        .key_code  (key_code),
        .drinks    (drinks),
        .buy       (buy),
        .buy_drink (buy_drink),
        .buy_cost  (buy_cost)
    );

    credit_fsm i_credit (
        .clk          (clk),
        .rst_n        (rst_n),
        .coin_pulse   (coin_pulse),
        .cancel_pulse (cancel_pulse),
        .buy          (buy),
        .buy_drink    (buy_drink),
        .buy_cost     (buy_cost),
        .refund_tick  (refund_tick),
        .money        (money),
        .drinks       (drinks),
        .dispense     (dispense),
        .refunding    (refunding)
    );

    tick_gen #(
        .REFUND_DIV (REFUND_DIV),
        .SCAN_DIV   (SCAN_DIV)
    ) i_ticks (
        .clk         (clk),
        .rst_n       (rst_n),
        .refunding   (refunding),
        .refund_tick (refund_tick),
        .scan_tick   (scan_tick)
    );

    display_scan i_display (
        .clk       (clk),
        .rst_n     (rst_n),
        .scan_tick (scan_tick),
        .money     (money),
        .an        (an),
        .seg       (seg)
    );

endmodule

`default_nettype wire

//--- design/display_scan.sv
`timescale 1ns/100ps
`default_nettype none

module display_scan (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             scan_tick,
    input  wire vend_pkg::money_t money,
    output disp_pkg::anode_t      an,
    output disp_pkg::seg_t        seg
);

    import disp_pkg::*;

    localparam int POS_W = $clog2(NUM_DIGITS);

    logic [POS_W-1:0] pos;
    digit_t           hund_d;
    digit_t           tens_d;
    digit_t           ones_d;
    digit_t           digit;

    // leading zeros blank, ones always shown
    always_comb begin
        hund_d = (money >= 8'd100) ? digit_t'(money / 8'd100) : DIGIT_BLANK;
        tens_d = (money >= 8'd10) ? digit_t'((money / 8'd10) % 8'd10) : DIGIT_BLANK;
        ones_d = digit_t'(money % 8'd10);
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pos   <= '0;
            an    <= AN_OFF;
            digit <= DIGIT_BLANK;
        end else if (scan_tick) begin
            pos <= pos + 1'b1;
            case (pos)
                POS_W'(0): begin
                    digit <= tens_d;
                    an    <= AN_TENS;
                end
                POS_W'(1): begin
                    digit <= hund_d;
                    an    <= AN_HUNDREDS;
                end
                POS_W'(2): begin
                    digit <= ones_d;
                    an    <= AN_ONES;
                end
                default: begin
                    digit <= DIGIT_BLANK;   // unused fourth position
                    an    <= AN_OFF;
                end
            endcase
        end
    end

    always_comb begin
        if (digit < 4'd10) begin
            seg = SEG_DIGITS[digit];
        end else begin
            seg = SEG_BLANK;
        end
    end

    a_one_anode: assert property (@(posedge clk) disable iff (rst_n)
        $countones(~an) <= 1);

endmodule

`default_nettype wire

//--- design/credit_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module credit_fsm (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire vend_pkg::coin_t  coin_pulse,
    input  wire logic             cancel_pulse,
    input  wire logic             buy,
    input  wire vend_pkg::drink_t buy_drink,
    input  wire vend_pkg::money_t buy_cost,
    input  wire logic             refund_tick,
    output vend_pkg::money_t      money,
    output vend_pkg::drink_t      drinks,
    output vend_pkg::drink_t      dispense,
    output logic                  refunding
);

    import vend_pkg::*;

    typedef enum logic {
        COLLECT,
        REFUND
    } state_t;

    state_t     state;
    state_t     state_n;
    money_t     money_n;
    money_t     coin_val;
    logic [8:0] coin_sum;   // extra bit for the carry
    money_t     coin_sat;

    always_comb begin
        case (coin_pulse)
            COIN_50: coin_val = COIN_VALUE_50;
            COIN_10: coin_val = COIN_VALUE_10;
            COIN_5:  coin_val = COIN_VALUE_5;
            default: coin_val = '0;   // none or several coins at once
        endcase
    end

    assign coin_sum = {1'b0, money} + {1'b0, coin_val};
    assign coin_sat = (coin_sum > {1'b0, CREDIT_MAX}) ? CREDIT_MAX : coin_sum[7:0];

    always_comb begin
        state_n = state;
        money_n = money;
        case (state)
            COLLECT: begin
                if (buy) begin
                    money_n = (money > buy_cost) ? money - buy_cost : '0;
                    state_n = REFUND;
                end else if (cancel_pulse && money != '0) begin
                    state_n = REFUND;
                end else begin
                    money_n = coin_sat;
                end
            end
            default: begin
                if (refund_tick) begin
                    money_n = (money > REFUND_STEP) ? money - REFUND_STEP : '0;
                end
                if (money_n == '0) begin
                    state_n = COLLECT;   // change fully returned
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state    <= COLLECT;
            money    <= '0;
            dispense <= '0;
        end else begin
            state    <= state_n;
            money    <= money_n;
            dispense <= (buy && state == COLLECT) ? buy_drink : '0;
        end
    end

    assign refunding = (state == REFUND);

    assign drinks = refunding ? '0 : {money >= PRICE_COFFEE, money >= PRICE_COKE,
                                      money >= PRICE_OOLONG, money >= PRICE_WATER};

    a_money_cap: assert property (@(posedge clk) disable iff (rst_n)
        money <= CREDIT_MAX);

    a_no_coin_in_refund: assert property (@(posedge clk) disable iff (rst_n)
        refunding |=> money <= $past(money));

endmodule

`default_nettype wire

//--- design/drink_selector.sv
`timescale 1ns/100ps
`default_nettype none

module drink_selector (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                key_valid,
    input  wire vend_pkg::key_code_t key_code,
    input  wire vend_pkg::drink_t    drinks,
    output logic                     buy,
    output vend_pkg::drink_t         buy_drink,
    output vend_pkg::money_t         buy_cost
);

    import vend_pkg::*;

    drink_t sel_drink;
    money_t sel_cost;
    logic   hit;

    always_comb begin
        case (key_code)
            KEY_COFFEE: begin
                sel_drink = DRINK_COFFEE;
                sel_cost  = PRICE_COFFEE;
            end
            KEY_COKE: begin
                sel_drink = DRINK_COKE;
                sel_cost  = PRICE_COKE;
            end
            KEY_OOLONG: begin
                sel_drink = DRINK_OOLONG;
                sel_cost  = PRICE_OOLONG;
            end
            KEY_WATER: begin
                sel_drink = DRINK_WATER;
                sel_cost  = PRICE_WATER;
            end
            default: begin
                sel_drink = '0;   // unknown key
                sel_cost  = '0;
            end
        endcase
    end

    // only affordable drinks get through
    assign hit = key_valid && ((sel_drink & drinks) != '0);

    always_ff @(posedge clk) begin
        if (rst_n) begin
            buy <= 1'b0;
        end else begin
            buy <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            buy_drink <= sel_drink;
            buy_cost  <= sel_cost;
        end
    end

    a_buy_onehot: assert property (@(posedge clk) disable iff (rst_n)
        buy |-> $onehot(buy_drink));

endmodule

`default_nettype wire

//--- design/tick_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tick_gen #(
    parameter int REFUND_DIV = 8,
    parameter int SCAN_DIV   = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic refunding,
    output logic      refund_tick,
    output logic      scan_tick
);

    localparam int RW = (REFUND_DIV > 1) ? $clog2(REFUND_DIV) : 1;
    localparam int SW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [RW-1:0] refund_cnt;
    logic [SW-1:0] scan_cnt;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            refund_cnt  <= '0;
            refund_tick <= 1'b0;
        end else if (!refunding) begin
            refund_cnt  <= '0;   // restart so the first step is a full period away
            refund_tick <= 1'b0;
        end else if (refund_cnt == RW'(REFUND_DIV - 1)) begin
            refund_cnt  <= '0;
            refund_tick <= 1'b1;
        end else begin
            refund_cnt  <= refund_cnt + 1'b1;
            refund_tick <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            scan_cnt  <= '0;
            scan_tick <= 1'b0;
        end else if (scan_cnt == SW'(SCAN_DIV - 1)) begin
            scan_cnt  <= '0;
            scan_tick <= 1'b1;
        end else begin
            scan_cnt  <= scan_cnt + 1'b1;
            scan_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/input_conditioner.sv
`timescale 1ns/100ps
`default_nettype none

module input_conditioner #(
    parameter type sig_t        = logic,
    parameter int  DEBOUNCE_LEN = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire sig_t raw,
    output sig_t      pulse
);

    localparam int W = $bits(sig_t);

    logic [DEBOUNCE_LEN-1:0] hist [W];   // newest sample in bit 0
    logic [W-1:0]            raw_b;
    logic [W-1:0]            level;
    logic [W-1:0]            level_q;
    logic [W-1:0]            pulse_q;

    assign raw_b = raw;

    always_comb begin
        for (int i = 0; i < W; i++) begin
            level[i] = &hist[i];   // stable high over the whole window
        end
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < W; i++) begin
                hist[i] <= '0;
            end
            level_q <= '0;
            pulse_q <= '0;
        end else begin
            for (int i = 0; i < W; i++) begin
                hist[i] <= {hist[i][DEBOUNCE_LEN-2:0], raw_b[i]};
            end
            level_q <= level;
            pulse_q <= level & ~level_q;   // rising edge only
        end
    end

    assign pulse = pulse_q;

    a_single_pulse: assert property (@(posedge clk) disable iff (rst_n)
        |pulse_q |=> ~|(pulse_q & $past(pulse_q)));

endmodule

`default_nettype wire

//--- design/disp_pkg.sv
`default_nettype none

package disp_pkg;

    typedef logic [6:0] seg_t;     // active low, segment a in bit 6
    typedef logic [3:0] anode_t;   // active low
    typedef logic [3:0] digit_t;

    localparam int NUM_DIGITS = 4;

    localparam digit_t DIGIT_BLANK = 4'd10;

    localparam seg_t SEG_BLANK = 7'b1111111;

    localparam seg_t SEG_DIGITS [10] = '{
        7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110, 7'b1001100,
        7'b0100100, 7'b0100000, 7'b0001111, 7'b0000000, 7'b0000100
    };

    localparam anode_t AN_ONES     = 4'b1110;
    localparam anode_t AN_TENS     = 4'b1101;
    localparam anode_t AN_HUNDREDS = 4'b1011;
    localparam anode_t AN_OFF      = 4'b1111;

endpackage

`default_nettype wire

//--- design/vend_pkg.sv
`default_nettype none

package vend_pkg;

    typedef logic [7:0] money_t;
    typedef logic [2:0] coin_t;      // bit 0 = 50, bit 1 = 10, bit 2 = 5
    typedef logic [3:0] drink_t;     // coffee, coke, oolong, water from msb
    typedef logic [8:0] key_code_t;

    localparam coin_t COIN_50 = 3'b001;
    localparam coin_t COIN_10 = 3'b010;
    localparam coin_t COIN_5  = 3'b100;

    localparam money_t COIN_VALUE_50 = 8'd50;
    localparam money_t COIN_VALUE_10 = 8'd10;
    localparam money_t COIN_VALUE_5  = 8'd5;

    localparam money_t PRICE_COFFEE = 8'd80;
    localparam money_t PRICE_COKE   = 8'd30;
    localparam money_t PRICE_OOLONG = 8'd25;
    localparam money_t PRICE_WATER  = 8'd20;

    localparam drink_t DRINK_COFFEE = 4'b1000;
    localparam drink_t DRINK_COKE   = 4'b0100;
    localparam drink_t DRINK_OOLONG = 4'b0010;
    localparam drink_t DRINK_WATER  = 4'b0001;

    // scan codes of the A, S, D and F keys
    localparam key_code_t KEY_COFFEE = 9'h01C;
    localparam key_code_t KEY_COKE   = 9'h01B;
    localparam key_code_t KEY_OOLONG = 9'h023;
    localparam key_code_t KEY_WATER  = 9'h02B;

    localparam money_t CREDIT_MAX  = 8'd100;
    localparam money_t REFUND_STEP = 8'd5;

endpackage

`default_nettype wire
